/* rtl/stq_defs.svh */
`ifndef STQ_DEFS_SVH
`define STQ_DEFS_SVH

// ==================================================
// store queue geometry
// ==================================================
`define STQ_DEPTH 16 // entries in the circular buffer.
`define STQ_IDX_W 4
`define STQ_ADDR_W 30 // word address, byte offset dropped.
`define STQ_DATA_W 32
`define STQ_BYTES 4

// ==================================================
// cache writeback
// ==================================================
`define STQ_WB_CREDITS 4 // credits held after reset.

`endif

/* rtl/stq_pkg.sv */
`include "stq_defs.svh"

package stq_pkg;

  // ==================================================
  // shared vector types
  // ==================================================
  typedef logic [`STQ_IDX_W-1:0] sq_idx_t;
  typedef logic [`STQ_ADDR_W-1:0] word_addr_t;
  typedef logic [`STQ_DATA_W-1:0] word_data_t;
  typedef logic [`STQ_BYTES-1:0] byte_mask_t;
  typedef logic [`STQ_DEPTH-1:0] entry_vec_t; // one bit per entry.

  // must hold the full grant, so one bit wider than the grant index.
  typedef logic [$clog2(`STQ_WB_CREDITS+1)-1:0] credit_t;

endpackage

/* rtl/stq_addr_array.sv */
`timescale 1ns/1ps
`include "stq_defs.svh"

module stq_addr_array (
  input  logic                clk,
  input  logic                reset,
  input  logic                excpt,
  input  logic                wrt0_en,
  input  stq_pkg::sq_idx_t    wrt0_idx,
  input  stq_pkg::word_addr_t wrt0_addr,
  input  stq_pkg::byte_mask_t wrt0_bytes,
  input  logic                wrt1_en,
  input  stq_pkg::sq_idx_t    wrt1_idx,
  input  stq_pkg::word_addr_t wrt1_addr,
  input  stq_pkg::byte_mask_t wrt1_bytes,
  input  logic                pse_en,
  input  stq_pkg::sq_idx_t    pse_idx,
  input  stq_pkg::entry_vec_t free_en,
  input  stq_pkg::word_addr_t chk0_addr,
  input  stq_pkg::byte_mask_t chk0_bytes,
  input  stq_pkg::word_addr_t chk1_addr,
  input  stq_pkg::byte_mask_t chk1_bytes,
  output stq_pkg::entry_vec_t chk0_match,
  output stq_pkg::entry_vec_t chk0_cover,
  output stq_pkg::entry_vec_t chk1_match,
  output stq_pkg::entry_vec_t chk1_cover,
  output stq_pkg::entry_vec_t entry_valid,
  output stq_pkg::entry_vec_t entry_passed,
  input  stq_pkg::sq_idx_t    head,
  output stq_pkg::word_addr_t head_addr,
  output stq_pkg::byte_mask_t head_bytes
);

  stq_pkg::word_addr_t addr_q [`STQ_DEPTH];
  stq_pkg::byte_mask_t bytes_q [`STQ_DEPTH];
  stq_pkg::entry_vec_t valid_q;
  stq_pkg::entry_vec_t passed_q;

  // ==================================================
  // entry state
  // ==================================================
  always_ff @(posedge clk) begin
    if (wrt0_en) begin
      addr_q[wrt0_idx]  <= wrt0_addr;
      bytes_q[wrt0_idx] <= wrt0_bytes;
    end
    if (wrt1_en) begin
      addr_q[wrt1_idx]  <= wrt1_addr;
      bytes_q[wrt1_idx] <= wrt1_bytes;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q  <= '0;
      passed_q <= '0;
    end else begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        if ((wrt0_en && wrt0_idx == stq_pkg::sq_idx_t'(i)) ||
            (wrt1_en && wrt1_idx == stq_pkg::sq_idx_t'(i))) begin
          valid_q[i]  <= !excpt; // new store flushed with its path.
          passed_q[i] <= 1'b0;
        end else if (free_en[i] || (excpt && !passed_q[i])) begin
          valid_q[i]  <= 1'b0;
          passed_q[i] <= 1'b0;
        end else if (pse_en && pse_idx == stq_pkg::sq_idx_t'(i)) begin
          passed_q[i] <= 1'b1;
        end
      end
    end
  end

  assign entry_valid  = valid_q;
  assign entry_passed = passed_q;
  assign head_addr    = addr_q[head];
  assign head_bytes   = bytes_q[head];

  // ==================================================
  // load compare
  // ==================================================
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      chk0_match[i] = valid_q[i] && addr_q[i] == chk0_addr && |(bytes_q[i] & chk0_bytes);
      chk0_cover[i] = (bytes_q[i] & chk0_bytes) == chk0_bytes; // all load bytes stored.
      chk1_match[i] = valid_q[i] && addr_q[i] == chk1_addr && |(bytes_q[i] & chk1_bytes);
      chk1_cover[i] = (bytes_q[i] & chk1_bytes) == chk1_bytes;
    end
  end

  // allocation only reuses an entry once the drain has released it.
  a_wrt0_free: assert property (@(posedge clk) disable iff (reset)
    wrt0_en |-> !valid_q[wrt0_idx] || free_en[wrt0_idx]);

  a_wrt1_free: assert property (@(posedge clk) disable iff (reset)
    wrt1_en |-> !valid_q[wrt1_idx] || free_en[wrt1_idx]);

endmodule

/* rtl/stq_data_array.sv */
`timescale 1ns/1ps
`include "stq_defs.svh"

module stq_data_array (
  input  logic                clk,
  input  logic                reset,
  input  logic                excpt,
  input  logic                upd_en,
  input  stq_pkg::sq_idx_t    upd_idx,
  input  stq_pkg::word_data_t upd_data,
  input  stq_pkg::entry_vec_t free_en,
  input  stq_pkg::entry_vec_t entry_passed,
  input  stq_pkg::entry_vec_t rd0_sel,
  input  stq_pkg::entry_vec_t rd1_sel,
  input  stq_pkg::sq_idx_t    head,
  output stq_pkg::word_data_t rd0_data,
  output stq_pkg::word_data_t rd1_data,
  output stq_pkg::word_data_t head_data,
  output stq_pkg::entry_vec_t data_ready
);

  stq_pkg::word_data_t data_q [`STQ_DEPTH];
  stq_pkg::entry_vec_t ready_q;

  always_ff @(posedge clk) begin
    if (upd_en) begin
      data_q[upd_idx] <= upd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ready_q <= '0;
    end else begin
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        if (free_en[i] || (excpt && !entry_passed[i])) begin
          ready_q[i] <= 1'b0;
        end else if (upd_en && upd_idx == stq_pkg::sq_idx_t'(i)) begin
          ready_q[i] <= 1'b1;
        end
      end
    end
  end

  // ==================================================
  // read ports
  // ==================================================
  always_comb begin
    rd0_data = '0;
    rd1_data = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      rd0_data |= {`STQ_DATA_W{rd0_sel[i]}} & data_q[i]; // select is one-hot.
      rd1_data |= {`STQ_DATA_W{rd1_sel[i]}} & data_q[i];
    end
  end

  assign head_data  = data_q[head];
  assign data_ready = ready_q;

endmodule

/* rtl/stq_fwd.sv */
`timescale 1ns/1ps
`include "stq_defs.svh"

module stq_fwd (
  input  logic                clk,
  input  logic                reset,
  input  logic                chk_en,
  input  stq_pkg::sq_idx_t    chk_pos,
  input  stq_pkg::sq_idx_t    head,
  input  stq_pkg::entry_vec_t match,
  input  stq_pkg::entry_vec_t cover_vec,
  input  stq_pkg::entry_vec_t data_ready,
  input  stq_pkg::word_data_t rd_data,
  output stq_pkg::entry_vec_t rd_sel,
  output logic                chk_valid,
  output logic                chk_hit,
  output logic                chk_retry,
  output stq_pkg::word_data_t chk_data
);

  stq_pkg::entry_vec_t below_pos;
  stq_pkg::entry_vec_t from_head;
  stq_pkg::entry_vec_t lo_win;
  stq_pkg::entry_vec_t pick_lo;
  stq_pkg::entry_vec_t pick_hi;
  logic                wrapped;
  logic                found;
  logic                covered;

  // one-hot of the highest set bit.
  function automatic stq_pkg::entry_vec_t pick_high(input stq_pkg::entry_vec_t v);
    stq_pkg::entry_vec_t r;
    r = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (v[i]) begin
        r = stq_pkg::entry_vec_t'(1) << i;
      end
    end
    return r;
  endfunction

  // ==================================================
  // age window
  // ==================================================
  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      below_pos[i] = stq_pkg::sq_idx_t'(i) < chk_pos;
      from_head[i] = stq_pkg::sq_idx_t'(i) >= head;
    end
  end

  assign wrapped = head > chk_pos; // older stores span the top of the ring.
  assign lo_win  = wrapped ? below_pos : below_pos & from_head;

  // youngest older store, low segment first.
  assign pick_lo = pick_high(match & lo_win);
  assign pick_hi = wrapped ? pick_high(match & from_head) : '0;
  assign rd_sel  = |pick_lo ? pick_lo : pick_hi;

  assign found   = |rd_sel;
  assign covered = |(rd_sel & cover_vec & data_ready);

  // ==================================================
  // result stage
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      chk_valid <= 1'b0;
      chk_hit   <= 1'b0;
      chk_retry <= 1'b0;
    end else begin
      chk_valid <= chk_en;
      chk_hit   <= chk_en && covered;
      chk_retry <= chk_en && found && !covered; // partial or data pending.
    end
  end

  always_ff @(posedge clk) begin
    if (chk_en) begin
      chk_data <= rd_data;
    end
  end

endmodule

/* rtl/stq_drain.sv */
`timescale 1ns/1ps
`include "stq_defs.svh"

module stq_drain (
  input  logic                clk,
  input  logic                reset,
  input  stq_pkg::entry_vec_t entry_valid,
  input  stq_pkg::entry_vec_t entry_passed,
  input  stq_pkg::entry_vec_t data_ready,
  input  stq_pkg::word_addr_t head_addr,
  input  stq_pkg::byte_mask_t head_bytes,
  input  stq_pkg::word_data_t head_data,
  input  logic                wb_credit,
  output stq_pkg::sq_idx_t    head,
  output stq_pkg::entry_vec_t free_en,
  output logic                wb_en,
  output stq_pkg::word_addr_t wb_addr,
  output stq_pkg::byte_mask_t wb_bytes,
  output stq_pkg::word_data_t wb_data
);

  stq_pkg::sq_idx_t head_q;
  stq_pkg::credit_t credit_q;
  logic             issue;

  // head still names the entry in flight while wb_en is high.
  assign issue = entry_valid[head_q] && entry_passed[head_q] && data_ready[head_q] &&
                 credit_q != '0 && !wb_en;

  assign head    = head_q;
  assign free_en = wb_en ? stq_pkg::entry_vec_t'(1) << head_q : '0;

  // ==================================================
  // head pointer and writeback
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      head_q <= '0;
      wb_en  <= 1'b0;
    end else begin
      wb_en <= issue;
      if (wb_en) begin
        head_q <= head_q + 1'b1; // ring wraps at the index width.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      wb_addr  <= head_addr;
      wb_bytes <= head_bytes;
      wb_data  <= head_data;
    end
  end

  // ==================================================
  // credits
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_q <= stq_pkg::credit_t'(`STQ_WB_CREDITS);
    end else begin
      credit_q <= credit_q - stq_pkg::credit_t'(issue) + stq_pkg::credit_t'(wb_credit);
    end
  end

  // cache returns no more than it was given.
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credit_q <= stq_pkg::credit_t'(`STQ_WB_CREDITS));

endmodule

/* rtl/stq.sv */
`timescale 1ns/1ps

module stq (
  input  logic                clk,
  input  logic                reset,
  input  logic                excpt,
  input  logic                wrt0_en,
  input  stq_pkg::sq_idx_t    wrt0_idx,
  input  stq_pkg::word_addr_t wrt0_addr,
  input  stq_pkg::byte_mask_t wrt0_bytes,
  input  logic                wrt1_en,
  input  stq_pkg::sq_idx_t    wrt1_idx,
  input  stq_pkg::word_addr_t wrt1_addr,
  input  stq_pkg::byte_mask_t wrt1_bytes,
  input  logic                upd_en,
  input  stq_pkg::sq_idx_t    upd_idx,
  input  stq_pkg::word_data_t upd_data,
  input  logic                pse_en,
  input  stq_pkg::sq_idx_t    pse_idx,
  input  logic                chk0_en,
  input  stq_pkg::word_addr_t chk0_addr,
  input  stq_pkg::byte_mask_t chk0_bytes,
  input  stq_pkg::sq_idx_t    chk0_pos,
  output logic                chk0_valid,
  output logic                chk0_hit,
  output logic                chk0_retry,
  output stq_pkg::word_data_t chk0_data,
  input  logic                chk1_en,
  input  stq_pkg::word_addr_t chk1_addr,
  input  stq_pkg::byte_mask_t chk1_bytes,
  input  stq_pkg::sq_idx_t    chk1_pos,
  output logic                chk1_valid,
  output logic                chk1_hit,
  output logic                chk1_retry,
  output stq_pkg::word_data_t chk1_data,
  output logic                wb_en,
  output stq_pkg::word_addr_t wb_addr,
  output stq_pkg::byte_mask_t wb_bytes,
  output stq_pkg::word_data_t wb_data,
  input  logic                wb_credit
);

  stq_pkg::entry_vec_t chk0_match;
  stq_pkg::entry_vec_t chk0_cover;
  stq_pkg::entry_vec_t chk1_match;
  stq_pkg::entry_vec_t chk1_cover;
  stq_pkg::entry_vec_t entry_valid;
  stq_pkg::entry_vec_t entry_passed;
  stq_pkg::entry_vec_t data_ready;
  stq_pkg::entry_vec_t free_en;
  stq_pkg::entry_vec_t rd0_sel;
  stq_pkg::entry_vec_t rd1_sel;
  stq_pkg::word_data_t rd0_data;
  stq_pkg::word_data_t rd1_data;
  stq_pkg::sq_idx_t    head;
  stq_pkg::word_addr_t head_addr;
  stq_pkg::byte_mask_t head_bytes;
  stq_pkg::word_data_t head_data;

  // ==================================================
  // entry arrays
  // ==================================================
  stq_addr_array u_addr (
    .clk(clk), .reset(reset), .excpt(excpt),
    .wrt0_en(wrt0_en), .wrt0_idx(wrt0_idx), .wrt0_addr(wrt0_addr), .wrt0_bytes(wrt0_bytes),
    .wrt1_en(wrt1_en), .wrt1_idx(wrt1_idx), .wrt1_addr(wrt1_addr), .wrt1_bytes(wrt1_bytes),
    .pse_en(pse_en), .pse_idx(pse_idx), .free_en(free_en),
    .chk0_addr(chk0_addr), .chk0_bytes(chk0_bytes),
    .chk1_addr(chk1_addr), .chk1_bytes(chk1_bytes),
    .chk0_match(chk0_match), .chk0_cover(chk0_cover),
    .chk1_match(chk1_match), .chk1_cover(chk1_cover),
    .entry_valid(entry_valid), .entry_passed(entry_passed),
    .head(head), .head_addr(head_addr), .head_bytes(head_bytes)
  );

  stq_data_array u_data (
    .clk(clk), .reset(reset), .excpt(excpt),
    .upd_en(upd_en), .upd_idx(upd_idx), .upd_data(upd_data),
    .free_en(free_en), .entry_passed(entry_passed),
    .rd0_sel(rd0_sel), .rd1_sel(rd1_sel), .head(head),
    .rd0_data(rd0_data), .rd1_data(rd1_data), .head_data(head_data),
    .data_ready(data_ready)
  );

  // ==================================================
  // forwarding search, one per load port
  // ==================================================
  stq_fwd u_fwd0 (
    .clk(clk), .reset(reset), .chk_en(chk0_en), .chk_pos(chk0_pos), .head(head),
    .match(chk0_match), .cover_vec(chk0_cover), .data_ready(data_ready),
    .rd_data(rd0_data), .rd_sel(rd0_sel),
    .chk_valid(chk0_valid), .chk_hit(chk0_hit), .chk_retry(chk0_retry), .chk_data(chk0_data)
  );

  stq_fwd u_fwd1 (
    .clk(clk), .reset(reset), .chk_en(chk1_en), .chk_pos(chk1_pos), .head(head),
    .match(chk1_match), .cover_vec(chk1_cover), .data_ready(data_ready),
    .rd_data(rd1_data), .rd_sel(rd1_sel),
    .chk_valid(chk1_valid), .chk_hit(chk1_hit), .chk_retry(chk1_retry), .chk_data(chk1_data)
  );

  stq_drain u_drain (
    .clk(clk), .reset(reset),
    .entry_valid(entry_valid), .entry_passed(entry_passed), .data_ready(data_ready),
    .head_addr(head_addr), .head_bytes(head_bytes), .head_data(head_data),
    .wb_credit(wb_credit), .head(head), .free_en(free_en),
    .wb_en(wb_en), .wb_addr(wb_addr), .wb_bytes(wb_bytes), .wb_data(wb_data)
  );

endmodule

/* dv/stq_tb.sv */
`timescale 1ns/1ps

module stq_tb;

  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] LFSR_SEED  = 32'h15d9_f262;

  logic                clk;
  logic                reset;
  logic                excpt;
  logic                wrt0_en;
  stq_pkg::sq_idx_t    wrt0_idx;
  stq_pkg::word_addr_t wrt0_addr;
  stq_pkg::byte_mask_t wrt0_bytes;
  logic                wrt1_en;
  stq_pkg::sq_idx_t    wrt1_idx;
  stq_pkg::word_addr_t wrt1_addr;
  stq_pkg::byte_mask_t wrt1_bytes;
  logic                upd_en;
  stq_pkg::sq_idx_t    upd_idx;
  stq_pkg::word_data_t upd_data;
  logic                pse_en;
  stq_pkg::sq_idx_t    pse_idx;
  logic                chk0_en;
  stq_pkg::word_addr_t chk0_addr;
  stq_pkg::byte_mask_t chk0_bytes;
  stq_pkg::sq_idx_t    chk0_pos;
  logic                chk0_valid;
  logic                chk0_hit;
  logic                chk0_retry;
  stq_pkg::word_data_t chk0_data;
  logic                chk1_en;
  stq_pkg::word_addr_t chk1_addr;
  stq_pkg::byte_mask_t chk1_bytes;
  stq_pkg::sq_idx_t    chk1_pos;
  logic                chk1_valid;
  logic                chk1_hit;
  logic                chk1_retry;
  stq_pkg::word_data_t chk1_data;
  logic                wb_en;
  stq_pkg::word_addr_t wb_addr;
  stq_pkg::byte_mask_t wb_bytes;
  stq_pkg::word_data_t wb_data;
  logic                wb_credit;

  stq_pkg::word_addr_t wb_addr_q[$];
  stq_pkg::byte_mask_t wb_bytes_q[$];
  stq_pkg::word_data_t wb_data_q[$];
  logic [31:0]         lfsr;
  logic [31:0]         f [12];
  int                  pending_credits = 0;
  int                  held_writes = 0;
  logic                hold = 1'b0;
  int                  test_errors = 0;
  int                  total_errors = 0;
  int                  tests = 0;
  int                  failed_tests = 0;
  string               test_name = "";

  stq u_stq (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic clear_inputs();
    excpt   <= 1'b0;
    wrt0_en <= 1'b0;
    wrt1_en <= 1'b0;
    upd_en  <= 1'b0;
    pse_en  <= 1'b0;
    chk0_en <= 1'b0;
    chk1_en <= 1'b0;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("Fail %s exp %h got %h", name, exp, got);
      test_errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic close_test();
    if (test_name != "") begin
      tests++;
      if (test_errors == 0) begin
        $display("test %s: ok", test_name);
      end else begin
        $display("test %s: %0d errors", test_name, test_errors);
        failed_tests++;
      end
      total_errors += test_errors;
      test_errors = 0;
    end
  endtask

  task automatic wait_result();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!chk0_valid && !chk1_valid) begin
      if (cnt >= WAIT_LIMIT) stop_on_timeout("a check result");
      @(negedge clk);
      cnt++;
    end
  endtask

  // ==================================================
  // one stimulus line
  // ==================================================
  task automatic run_command(input string line);
    byte cmd;
    int  cnt;
    cmd = line.getc(0);
    void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]));
    case (cmd)
      "t": begin
        close_test();
        test_name = line.substr(2, line.len() - 2);
      end
      "w", "u", "p", "x", "c", "k": begin
        @(posedge clk);
        if (cmd == "w" && f[0] == 0) begin
          wrt0_en    <= 1'b1;
          wrt0_idx   <= f[1][3:0];
          wrt0_addr  <= f[2][29:0];
          wrt0_bytes <= f[3][3:0];
        end
        if (cmd == "w" && f[0] != 0) begin
          wrt1_en    <= 1'b1;
          wrt1_idx   <= f[1][3:0];
          wrt1_addr  <= f[2][29:0];
          wrt1_bytes <= f[3][3:0];
        end
        if (cmd == "w" && f[5][0]) begin
          upd_en   <= 1'b1; // data with the address.
          upd_idx  <= f[1][3:0];
          upd_data <= f[4];
        end
        if (cmd == "u") begin
          upd_en   <= 1'b1;
          upd_idx  <= f[0][3:0];
          upd_data <= f[1];
        end
        if (cmd == "p") begin
          pse_en  <= 1'b1;
          pse_idx <= f[0][3:0];
        end
        if (cmd == "x") excpt <= 1'b1;
        if (cmd == "c" || cmd == "k") begin
          chk0_en    <= 1'b1;
          chk0_addr  <= f[0][29:0];
          chk0_bytes <= f[1][3:0];
          chk0_pos   <= f[2][3:0];
        end
        if (cmd == "k") begin
          chk1_en    <= 1'b1;
          chk1_addr  <= f[6][29:0];
          chk1_bytes <= f[7][3:0];
          chk1_pos   <= f[8][3:0];
        end
        @(posedge clk);
        clear_inputs();
        if (cmd == "c" || cmd == "k") begin
          wait_result();
          compare("chk0_valid", 1, chk0_valid);
          compare("chk0_hit", f[3], chk0_hit);
          compare("chk0_retry", f[4], chk0_retry);
          if (f[3][0]) compare("chk0_data", f[5], chk0_data);
        end
        if (cmd == "k") begin
          compare("chk1_valid", 1, chk1_valid); // both ports answer together.
          compare("chk1_hit", f[9], chk1_hit);
          compare("chk1_retry", f[10], chk1_retry);
          if (f[9][0]) compare("chk1_data", f[11], chk1_data);
        end
        if (cmd == "c" || cmd == "k") begin
          @(negedge clk);
          compare("chk0_valid", 0, chk0_valid); // result lasts one cycle.
          compare("chk1_valid", 0, chk1_valid);
        end
      end
      "d": begin
        cnt = 0;
        while (wb_addr_q.size() == 0) begin
          if (cnt >= WAIT_LIMIT) stop_on_timeout("a writeback");
          @(negedge clk);
          cnt++;
        end
        compare("wb_addr", f[0], wb_addr_q.pop_front());
        compare("wb_bytes", f[1], wb_bytes_q.pop_front());
        compare("wb_data", f[2], wb_data_q.pop_front());
      end
      "n": repeat (f[0]) @(posedge clk);
      "h": begin
        if (f[0][0]) begin
          held_writes = 0;
          hold = 1'b1;
        end else begin
          compare("writes while credits held", f[1], held_writes);
          hold = 1'b0;
        end
      end
      default: begin
        $display("unknown stimulus command in line: %s", line);
        test_errors++;
      end
    endcase
  endtask

  // ==================================================
  // cache model
  // ==================================================
  always @(negedge clk) begin
    if (!reset && wb_en) begin
      wb_addr_q.push_back(wb_addr);
      wb_bytes_q.push_back(wb_bytes);
      wb_data_q.push_back(wb_data);
      pending_credits++;
      held_writes++;
    end
  end

  initial begin
    logic [2:0] delay;
    wb_credit = 1'b0;
    lfsr = LFSR_SEED;
    forever begin
      @(posedge clk);
      if (!reset && !hold && pending_credits > 0) begin
        for (int i = 0; i < 3; i++) begin
          delay = {delay[1:0], lfsr[0]};
          lfsr = lfsr_next(lfsr);
        end
        repeat (delay) @(posedge clk);
        wb_credit <= 1'b1;
        pending_credits--;
        @(posedge clk);
        wb_credit <= 1'b0;
      end
    end
  end

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    int    fd;
    string line;
    reset = 1'b1;
    excpt = 1'b0;
    wrt0_en = 1'b0;
    wrt0_idx = '0;
    wrt0_addr = '0;
    wrt0_bytes = '0;
    wrt1_en = 1'b0;
    wrt1_idx = '0;
    wrt1_addr = '0;
    wrt1_bytes = '0;
    upd_en = 1'b0;
    upd_idx = '0;
    upd_data = '0;
    pse_en = 1'b0;
    pse_idx = '0;
    chk0_en = 1'b0;
    chk0_addr = '0;
    chk0_bytes = '0;
    chk0_pos = '0;
    chk1_en = 1'b0;
    chk1_addr = '0;
    chk1_bytes = '0;
    chk1_pos = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    fd = $fopen("dv/stq_stimulus.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file dv/stq_stimulus.txt could not be opened");
      total_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == 8'h23) continue; // blank or comment.
        run_command(line);
      end
      $fclose(fd);
    end
    repeat (40) @(posedge clk);
    if (wb_addr_q.size() != 0) begin
      $display("unexpected writeback of %0d stores after the last test", wb_addr_q.size());
      test_errors++;
    end
    close_test();
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* dv/stq_stimulus.txt */
# w port idx addr bytes data dv | u idx data | p idx | x | n cycles | h on writes
# c addr bytes pos hit retry data | k = c fields port0 then port1 | d addr bytes data
t fwd_hit
w 0 0 00000100 f 11223344 1
c 00000100 3 1 1 0 11223344
t fwd_retry
w 1 1 00000200 3 0 0
c 00000200 1 2 0 1 0
u 1 aabbccdd
c 00000200 6 2 0 1 0
c 00000300 f 2 0 0 0
t fwd_age
w 0 2 00000400 f 01010101 1
w 1 3 00000400 f 02020202 1
k 00000400 f 3 1 0 01010101 00000400 f 4 1 0 02020202
t drain_order
p 0
p 1
p 2
p 3
d 00000100 f 11223344
d 00000200 3 aabbccdd
d 00000400 f 01010101
d 00000400 f 02020202
n 80
t drain_credit
h 1 0
w 0 4 00000800 f 80000004 1
w 1 5 00000801 c 80000005 1
w 0 6 00000802 f 80000006 1
w 1 7 00000803 3 80000007 1
w 0 8 00000804 f 80000008 1
p 4
p 5
p 6
p 7
p 8
n 30
h 0 4
d 00000800 f 80000004
d 00000801 c 80000005
d 00000802 f 80000006
d 00000803 3 80000007
d 00000804 f 80000008
t excpt
w 0 9 00000600 f 06060606 1
w 1 a 00000700 f 07070707 1
p 9
x
c 00000700 f b 0 0 0
d 00000600 f 06060606
t fwd_wrap
w 0 f 00000500 f 0f0f0f0f 1
w 1 0 00000500 f f0f0f0f0 1
k 00000500 f 0 1 0 0f0f0f0f 00000500 f 1 1 0 f0f0f0f0

/* stq.f */
+incdir+rtl
rtl/stq_pkg.sv
rtl/stq_addr_array.sv
rtl/stq_data_array.sv
rtl/stq_fwd.sv
rtl/stq_drain.sv
rtl/stq.sv
dv/stq_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module stq_tb -f stq.f -o stq_sim &&
./obj_dir/stq_sim | tee /dev/stderr | grep -Fx '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
